// ==== Bender.yml ====
package:
  name: hazard_unit

sources:
  - files:
      - rtl/hazPkg.sv
      - rtl/instrDecode.sv
      - rtl/stageTrack.sv
      - rtl/regHazard.sv
      - rtl/memHazard.sv
      - rtl/flowControl.sv
      - rtl/hazardCfg.sv
      - rtl/hazardUnit.sv
  - target: test
    files:
      - verif/hazardUnitTb.sv

// ==== rtl/flowControl.sv ====
`timescale 1ns/1ns

module flowControl (
    input  logic clk,
    input  logic rstN,
    input  logic isJump,
    input  logic regStall,
    input  logic memStall,
    output logic nop,
    output logic pcStall,
    output logic bubble
);

    logic jumpBubble;
    logic jumpBubbleQ;   // Jump bubble issued last cycle

    // One bubble per jump, the re-presented jump passes
    assign jumpBubble = isJump & ~jumpBubbleQ;

    assign nop     = regStall | memStall;
    assign pcStall = nop | jumpBubble;
    assign bubble  = nop;

    // A data stall re-presents the jump, so it still owes its bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            jumpBubbleQ <= 1'b0;
        end else begin
            jumpBubbleQ <= jumpBubble & ~nop;
        end
    end

endmodule

// ==== rtl/hazPkg.sv ====
package hazPkg;

    localparam int OpWidth      = 5;
    localparam int RegAddrWidth = 3;
    localparam int MemAddrWidth = 16;  // Same as the datapath width
    localparam int TrackDepth   = 4;   // ID, EX, MEM, WB

    // Destination of JAL and JALR
    localparam logic [RegAddrWidth-1:0] LinkReg = 3'd7;

    // Opcodes, top five bits of the instruction word
    localparam logic [OpWidth-1:0] OpNop  = 5'b00001;
    localparam logic [OpWidth-1:0] OpJ    = 5'b00100;
    localparam logic [OpWidth-1:0] OpJr   = 5'b00101;
    localparam logic [OpWidth-1:0] OpJal  = 5'b00110;
    localparam logic [OpWidth-1:0] OpJalr = 5'b00111;
    localparam logic [OpWidth-1:0] OpSt   = 5'b10000;
    localparam logic [OpWidth-1:0] OpLd   = 5'b10001;
    localparam logic [OpWidth-1:0] OpStu  = 5'b10011;

    // Branch group is 011xx
    localparam logic [2:0] OpBranchPfx = 3'b011;

    // One in-flight register write
    typedef struct packed {
        logic [RegAddrWidth-1:0] idx;
        logic                    valid;
    } regDestT;

    // One in-flight memory access
    typedef struct packed {
        logic [MemAddrWidth-1:0] addr;
        logic                    en;
    } memAccessT;

    // Forwarding selects, MSB first as the datapath expects them
    typedef struct packed {
        logic exToExRs;
        logic memToExRs;
        logic exToExRt;
        logic memToExRt;
        logic exToIdRs;   // Register jumps only
        logic memToIdRs;
    } fwdSelT;

    typedef struct packed {
        logic fwdEn;      // 0 stalls on every register match
        logic memChkEn;
    } hazCfgT;

    localparam hazCfgT CfgResetVal = '{fwdEn: 1'b0, memChkEn: 1'b1};

endpackage

// ==== rtl/hazardCfg.sv ====
`timescale 1ns/1ns

module hazardCfg (
    input  logic           clk,
    input  logic           rstN,
    input  logic           cfgWe,
    input  hazPkg::hazCfgT cfgWdata,
    output hazPkg::hazCfgT cfg,
    output hazPkg::hazCfgT cfgRdata
);

    hazPkg::hazCfgT cfgQ;

    // New mode applies from the cycle after the write
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfgQ <= hazPkg::CfgResetVal;   // Stall mode, memory check on
        end else if (cfgWe) begin
            cfgQ <= cfgWdata;
        end
    end

    assign cfg      = cfgQ;
    assign cfgRdata = cfgQ;   // Readback

endmodule

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit #(
    parameter int DataWidth = 16
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [DataWidth-1:0]            instr,
    input  logic [hazPkg::RegAddrWidth-1:0] rd,
    input  logic                            writesReg,
    input  logic                            memEnable,
    input  logic [DataWidth-1:0]            reg1Data,
    input  logic [DataWidth-1:0]            imm,
    input  logic                            branchTaken,
    input  logic                            cfgWe,
    input  hazPkg::hazCfgT                  cfgWdata,
    output logic                            nop,
    output logic                            pcStall,
    output hazPkg::fwdSelT                  forwards,
    output hazPkg::hazCfgT                  cfgRdata
);

    logic [hazPkg::RegAddrWidth-1:0] rs;
    logic [hazPkg::RegAddrWidth-1:0] rt;
    hazPkg::regDestT                 dest;
    hazPkg::regDestT                 destStages [hazPkg::TrackDepth];
    hazPkg::memAccessT               curAcc;
    hazPkg::memAccessT               accStages [hazPkg::TrackDepth];
    hazPkg::hazCfgT                  cfg;
    logic                            isJump;
    logic                            isMem;
    logic                            memAccess;
    logic                            idIsLoad;
    logic                            regStall;
    logic                            memStall;
    logic                            bubble;

    instrDecode #(.DataWidth(DataWidth)) u_decode (
        .instr(instr), .rd(rd), .writesReg(writesReg),
        .rs(rs), .rt(rt), .dest(dest), .isJump(isJump), .isMem(isMem)
    );

    // Access counts only when the datapath enables memory too
    assign memAccess = isMem & memEnable;

    stageTrack #(.PayloadT(hazPkg::regDestT)) u_regTrack (
        .clk(clk), .rstN(rstN), .din(dest), .bubble(bubble),
        .kill(branchTaken), .stages(destStages)
    );

    stageTrack #(.PayloadT(hazPkg::memAccessT)) u_memTrack (
        .clk(clk), .rstN(rstN), .din(curAcc), .bubble(bubble),
        .kill(branchTaken), .stages(accStages)
    );

    regHazard u_regHaz (
        .rs(rs), .rt(rt), .destStages(destStages), .idIsLoad(idIsLoad),
        .branchTaken(branchTaken), .cfg(cfg), .regStall(regStall), .forwards(forwards)
    );

    memHazard #(.DataWidth(DataWidth)) u_memHaz (
        .reg1Data(reg1Data), .imm(imm), .isMem(memAccess), .accStages(accStages),
        .branchTaken(branchTaken), .cfg(cfg), .cur(curAcc), .memStall(memStall),
        .idIsLoad(idIsLoad)
    );

    hazardCfg u_cfg (
        .clk(clk), .rstN(rstN), .cfgWe(cfgWe), .cfgWdata(cfgWdata),
        .cfg(cfg), .cfgRdata(cfgRdata)
    );

    flowControl u_flow (
        .clk(clk), .rstN(rstN), .isJump(isJump), .regStall(regStall),
        .memStall(memStall), .nop(nop), .pcStall(pcStall), .bubble(bubble)
    );

endmodule

// ==== rtl/instrDecode.sv ====
`timescale 1ns/1ns

module instrDecode #(
    parameter int DataWidth = 16
) (
    input  logic [DataWidth-1:0]              instr,
    input  logic [hazPkg::RegAddrWidth-1:0]   rd,
    input  logic                              writesReg,
    output logic [hazPkg::RegAddrWidth-1:0]   rs,
    output logic [hazPkg::RegAddrWidth-1:0]   rt,
    output hazPkg::regDestT                   dest,
    output logic                              isJump,
    output logic                              isMem
);

    localparam int RsMsb = DataWidth - hazPkg::OpWidth - 1;
    localparam int RtMsb = RsMsb - hazPkg::RegAddrWidth;

    logic [hazPkg::OpWidth-1:0] opcode;
    logic                       isLink;
    logic                       isBranch;
    logic                       isNop;

    assign opcode = instr[DataWidth-1 -: hazPkg::OpWidth];

    // Source fields sit right below the opcode
    assign rs = instr[RsMsb -: hazPkg::RegAddrWidth];
    assign rt = instr[RtMsb -: hazPkg::RegAddrWidth];

    always_comb begin
        isJump = 1'b0;
        isLink = 1'b0;
        isMem  = 1'b0;
        case (opcode)
            hazPkg::OpJ,
            hazPkg::OpJr:   isJump = 1'b1;
            hazPkg::OpJal,
            hazPkg::OpJalr: begin
                isJump = 1'b1;
                isLink = 1'b1;   // Writes the return address
            end
            hazPkg::OpLd,
            hazPkg::OpSt,
            hazPkg::OpStu:  isMem = 1'b1;
            default: ;
        endcase
    end

    assign isBranch = (opcode[hazPkg::OpWidth-1 -: 3] == hazPkg::OpBranchPfx);
    assign isNop    = (opcode == hazPkg::OpNop);

    // Branches and NOP never write, whatever the datapath claims
    always_comb begin
        dest.idx   = isLink ? hazPkg::LinkReg : rd;
        dest.valid = isLink | (writesReg & ~isBranch & ~isNop);
    end

endmodule

// ==== rtl/memHazard.sv ====
`timescale 1ns/1ns

module memHazard #(
    parameter int DataWidth = 16
) (
    input  logic [DataWidth-1:0] reg1Data,
    input  logic [DataWidth-1:0] imm,
    input  logic                 isMem,
    input  hazPkg::memAccessT    accStages [hazPkg::TrackDepth],
    input  logic                 branchTaken,
    input  hazPkg::hazCfgT       cfg,
    output hazPkg::memAccessT    cur,
    output logic                 memStall,
    output logic                 idIsLoad
);

    logic [DataWidth-1:0]          effAddr;
    logic [hazPkg::TrackDepth-1:0] addrHit;

    assign effAddr = reg1Data + imm;   // Base plus offset

    always_comb begin
        cur.addr = effAddr;
        cur.en   = isMem;
    end

    always_comb begin
        for (int i = 0; i < hazPkg::TrackDepth; i++) begin
            addrHit[i] = accStages[i].en && (accStages[i].addr == effAddr);
        end
        addrHit[0] = addrHit[0] & ~branchTaken;   // Squashed entry
    end

    assign memStall = cfg.memChkEn & isMem & (|addrHit);

    // Memory op in ID, its data reaches the datapath a cycle late
    assign idIsLoad = accStages[0].en & ~branchTaken;

endmodule

// ==== rtl/regHazard.sv ====
`timescale 1ns/1ns

module regHazard (
    input  logic [hazPkg::RegAddrWidth-1:0] rs,
    input  logic [hazPkg::RegAddrWidth-1:0] rt,
    input  hazPkg::regDestT                 destStages [hazPkg::TrackDepth],
    input  logic                            idIsLoad,
    input  logic                            branchTaken,
    input  hazPkg::hazCfgT                  cfg,
    output logic                            regStall,
    output hazPkg::fwdSelT                  forwards
);

    logic [hazPkg::TrackDepth-1:0] rsHit;
    logic [hazPkg::TrackDepth-1:0] rtHit;
    logic                          rsLoadUse;
    logic                          rtLoadUse;
    logic                          lateHit;

    always_comb begin
        for (int i = 0; i < hazPkg::TrackDepth; i++) begin
            rsHit[i] = destStages[i].valid && (destStages[i].idx == rs);
            rtHit[i] = destStages[i].valid && (destStages[i].idx == rt);
        end
        // ID entry is being killed this cycle
        rsHit[0] = rsHit[0] & ~branchTaken;
        rtHit[0] = rtHit[0] & ~branchTaken;
    end

    // Load data is not ready in time for EX to EX
    assign rsLoadUse = rsHit[0] & idIsLoad;
    assign rtLoadUse = rtHit[0] & idIsLoad;

    // MEM and WB writers have no forwarding path
    assign lateHit = rsHit[2] | rsHit[3] | rtHit[2] | rtHit[3];

    always_comb begin
        forwards = '0;
        if (cfg.fwdEn) begin
            forwards.exToExRs  = rsHit[0] & ~idIsLoad;
            forwards.memToExRs = rsHit[1] & ~rsHit[0];   // Younger writer wins
            forwards.exToExRt  = rtHit[0] & ~idIsLoad;
            forwards.memToExRt = rtHit[1] & ~rtHit[0];
            // Same matches, seen by a register jump resolving in ID
            forwards.exToIdRs  = rsHit[0] & ~idIsLoad;
            forwards.memToIdRs = rsHit[1] & ~rsHit[0];
            regStall = rsLoadUse | rtLoadUse | lateHit;
        end else begin
            regStall = (|rsHit) | (|rtHit);
        end
    end

endmodule

// ==== rtl/stageTrack.sv ====
`timescale 1ns/1ns

// History of the instructions ahead of fetch, stage 0 is ID
module stageTrack #(
    parameter type PayloadT = hazPkg::regDestT
) (
    input  logic    clk,
    input  logic    rstN,
    input  PayloadT din,
    input  logic    bubble,
    input  logic    kill,
    output PayloadT stages [hazPkg::TrackDepth]
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < hazPkg::TrackDepth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            // Fetch is held on a bubble, so nothing real enters ID
            stages[0] <= bubble ? PayloadT'('0) : din;
            // Taken branch squashes the ID entry on its way to EX
            stages[1] <= kill ? PayloadT'('0) : stages[0];
            for (int i = 2; i < hazPkg::TrackDepth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

endmodule

// ==== tb.f ====
rtl/hazPkg.sv
rtl/instrDecode.sv
rtl/stageTrack.sv
rtl/regHazard.sv
rtl/memHazard.sv
rtl/flowControl.sv
rtl/hazardCfg.sv
rtl/hazardUnit.sv
verif/hazardUnitTb.sv

// ==== verif/hazardUnitTb.sv ====
`timescale 1ns/1ns

module hazardUnitTb;

    localparam int DataWidth    = 16;
    localparam int ResetCycles  = 5;
    localparam int ResetTimeout = 50;     // Cycles
    localparam int RunLimitNs   = 20000;

    // Plain ALU op outside the jump, branch and memory groups
    localparam logic [hazPkg::OpWidth-1:0] OpAlu = 5'b01000;

    localparam hazPkg::fwdSelT FwdNone  = 6'b000000;
    localparam hazPkg::fwdSelT FwdEx    = 6'b100010;   // exToExRs and exToIdRs
    localparam hazPkg::fwdSelT FwdMem   = 6'b010001;   // memToExRs and memToIdRs
    localparam hazPkg::fwdSelT FwdExRt  = 6'b001000;   // exToExRt only
    localparam hazPkg::fwdSelT FwdMemRt = 6'b000100;   // memToExRt only

    // One cycle of stimulus with its expected response
    typedef struct packed {
        logic [DataWidth-1:0]            instr;
        logic [hazPkg::RegAddrWidth-1:0] rd;
        logic                            writesReg;
        logic                            memEnable;
        logic [DataWidth-1:0]            reg1Data;
        logic [DataWidth-1:0]            imm;
        logic                            branchTaken;
        logic                            expNop;
        logic                            expPcStall;
        hazPkg::fwdSelT                  expFwd;
    } rowT;

    logic                            clk;
    logic                            rstN;
    logic [DataWidth-1:0]            instr;
    logic [hazPkg::RegAddrWidth-1:0] rd;
    logic                            writesReg;
    logic                            memEnable;
    logic [DataWidth-1:0]            reg1Data;
    logic [DataWidth-1:0]            imm;
    logic                            branchTaken;
    logic                            cfgWe;
    hazPkg::hazCfgT                  cfgWdata;
    logic                            nop;
    logic                            pcStall;
    hazPkg::fwdSelT                  forwards;
    hazPkg::hazCfgT                  cfgRdata;

    rowT    rows [$];
    string  rowNames [$];
    int     fillCount;
    integer seed = 32'h87fa1ae1;

    hazardUnit #(.DataWidth(DataWidth)) u_dut (
        .clk(clk), .rstN(rstN), .instr(instr), .rd(rd), .writesReg(writesReg),
        .memEnable(memEnable), .reg1Data(reg1Data), .imm(imm),
        .branchTaken(branchTaken), .cfgWe(cfgWe), .cfgWdata(cfgWdata),
        .nop(nop), .pcStall(pcStall), .forwards(forwards), .cfgRdata(cfgRdata)
    );

    always #2 clk = ~clk;

    function automatic logic [DataWidth-1:0] encode(
        input logic [hazPkg::OpWidth-1:0]      op,
        input logic [hazPkg::RegAddrWidth-1:0] rs,
        input logic [hazPkg::RegAddrWidth-1:0] rt
    );
        return {op, rs, rt, 5'b00000};
    endfunction

    task automatic driveIdle();
        instr       = encode(OpAlu, 3'd0, 3'd0);
        rd          = '0;
        writesReg   = 1'b0;
        memEnable   = 1'b0;
        reg1Data    = '0;
        imm         = '0;
        branchTaken = 1'b0;
    endtask

    task automatic addRow(input string name, input rowT row);
        rows.push_back(row);
        rowNames.push_back(name);
    endtask

    task automatic addAlu(input string name, input logic [2:0] rs, input logic [2:0] rt,
                          input logic [2:0] dst, input logic wr, input logic taken,
                          input logic stall, input hazPkg::fwdSelT fwd);
        rowT row;
        row             = '0;
        row.instr       = encode(OpAlu, rs, rt);
        row.rd          = dst;
        row.writesReg   = wr;
        row.branchTaken = taken;
        row.expNop      = stall;
        row.expPcStall  = stall;
        row.expFwd      = fwd;
        addRow(name, row);
    endtask

    // Loads and stores with register fields at r0
    task automatic addMem(input string name, input logic [4:0] op, input logic [2:0] dst,
                          input logic wr, input logic [15:0] base, input logic [15:0] off,
                          input logic stall);
        rowT row;
        row            = '0;
        row.instr      = encode(op, 3'd0, 3'd0);
        row.rd         = dst;
        row.writesReg  = wr;
        row.memEnable  = 1'b1;
        row.reg1Data   = base;
        row.imm        = off;
        row.expNop     = stall;
        row.expPcStall = stall;
        row.expFwd     = FwdNone;
        addRow(name, row);
    endtask

    task automatic addJump(input string name, input logic [4:0] op, input logic jumpBubble);
        rowT row;
        row            = '0;
        row.instr      = encode(op, 3'd0, 3'd0);
        row.expPcStall = jumpBubble;   // Never a nop
        addRow(name, row);
    endtask

    // Independent rows that also drain the trackers
    task automatic addFill(input int count);
        rowT         row;
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            row          = '0;
            row.instr    = encode(OpAlu, 3'd0, 3'd0);   // Nothing ever writes r0
            rnd          = $random(seed);
            row.rd       = rnd[2:0];
            rnd          = $random(seed);
            row.imm      = rnd[15:0];
            row.reg1Data = rnd[31:16];
            addRow($sformatf("filler %0d", fillCount), row);
            fillCount++;
        end
    endtask

    task automatic checkRow(input string name, input rowT row);
        assert (nop === row.expNop) else begin
            $display("Mismatch %s: nop expected %0b actual %0b", name, row.expNop, nop);
            $display("** FAIL **");
            $fatal(1, "nop check failed");
        end
        assert (pcStall === row.expPcStall) else begin
            $display("Mismatch %s: pcStall expected %0b actual %0b", name,
                     row.expPcStall, pcStall);
            $display("** FAIL **");
            $fatal(1, "pcStall check failed");
        end
        assert (forwards === row.expFwd) else begin
            $display("Mismatch %s: forwards expected %b actual %b", name,
                     row.expFwd, forwards);
            $display("** FAIL **");
            $fatal(1, "forwards check failed");
        end
    endtask

    task automatic checkCfg(input string name, input hazPkg::hazCfgT expCfg);
        assert (cfgRdata === expCfg) else begin
            $display("Mismatch %s: cfgRdata expected %b actual %b", name, expCfg, cfgRdata);
            $display("** FAIL **");
            $fatal(1, "config readback failed");
        end
    endtask

    // Drive 1 ns after the edge and sample 1 ns before the next one
    task automatic runRows();
        rowT row;
        for (int i = 0; i < rows.size(); i++) begin
            row = rows[i];
            @(posedge clk);
            #1;
            instr       = row.instr;
            rd          = row.rd;
            writesReg   = row.writesReg;
            memEnable   = row.memEnable;
            reg1Data    = row.reg1Data;
            imm         = row.imm;
            branchTaken = row.branchTaken;
            #2;
            checkRow(rowNames[i], row);
        end
        rows.delete();
        rowNames.delete();
    endtask

    task automatic writeCfg(input logic newFwdEn, input logic newMemChkEn);
        hazPkg::hazCfgT expCfg;
        expCfg = '{fwdEn: newFwdEn, memChkEn: newMemChkEn};
        @(posedge clk);
        #1;
        driveIdle();
        cfgWe    = 1'b1;
        cfgWdata = expCfg;
        @(posedge clk);
        #1;
        cfgWe    = 1'b0;
        cfgWdata = '0;
        #1;
        checkCfg("cfg write", expCfg);
    endtask

    task automatic waitResetRelease();
        int cycles;
        cycles = 0;
        while (rstN !== 1'b1 && cycles < ResetTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            $display("Timeout: reset was never released");
            $display("** FAIL **");
            $fatal(1, "reset timeout");
        end
    endtask

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        cfgWe    = 1'b0;
        cfgWdata = '0;
        driveIdle();
        repeat (ResetCycles) @(posedge clk);
        #1 rstN = 1'b1;
    end

    initial begin
        #(RunLimitNs);
        $display("Timeout: run did not finish within %0d ns", RunLimitNs);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        fillCount = 0;
        waitResetRelease();
        #1;
        checkCfg("reset readback", '{fwdEn: 1'b0, memChkEn: 1'b1});
        addFill(3);
        runRows();

        // Stall mode reader of r3 through rt waits once per tracked stage
        addAlu("dep writer", 3'd1, 3'd2, 3'd3, 1'b1, 1'b0, 1'b0, FwdNone);
        addAlu("dep reader ID", 3'd4, 3'd3, 3'd5, 1'b1, 1'b0, 1'b1, FwdNone);
        addAlu("dep reader EX", 3'd4, 3'd3, 3'd5, 1'b1, 1'b0, 1'b1, FwdNone);
        addAlu("dep reader MEM", 3'd4, 3'd3, 3'd5, 1'b1, 1'b0, 1'b1, FwdNone);
        addAlu("dep reader WB", 3'd4, 3'd3, 3'd5, 1'b1, 1'b0, 1'b1, FwdNone);
        addAlu("dep reader go", 3'd4, 3'd3, 3'd5, 1'b1, 1'b0, 1'b0, FwdNone);
        addFill(4);

        // Taken branch kills the r3 writer on its way to EX
        addAlu("br writer", 3'd1, 3'd2, 3'd3, 1'b1, 1'b0, 1'b0, FwdNone);
        addAlu("br kill", 3'd3, 3'd4, 3'd5, 1'b1, 1'b1, 1'b0, FwdNone);
        addAlu("br after 1", 3'd3, 3'd3, 3'd0, 1'b0, 1'b0, 1'b0, FwdNone);
        addAlu("br after 2", 3'd3, 3'd3, 3'd0, 1'b0, 1'b0, 1'b0, FwdNone);
        addAlu("br after 3", 3'd3, 3'd3, 3'd0, 1'b0, 1'b0, 1'b0, FwdNone);
        addFill(4);

        // Jumps get one bubble and JAL is tracked twice as r7
        addJump("j bubble", hazPkg::OpJ, 1'b1);
        addJump("j again", hazPkg::OpJ, 1'b0);
        addFill(1);
        addJump("jal bubble", hazPkg::OpJal, 1'b1);
        addJump("jal again", hazPkg::OpJal, 1'b0);
        addAlu("link use 1", 3'd7, 3'd0, 3'd0, 1'b0, 1'b0, 1'b1, FwdNone);
        addAlu("link use 2", 3'd7, 3'd0, 3'd0, 1'b0, 1'b0, 1'b1, FwdNone);
        addAlu("link use 3", 3'd7, 3'd0, 3'd0, 1'b0, 1'b0, 1'b1, FwdNone);
        addAlu("link use 4", 3'd7, 3'd0, 3'd0, 1'b0, 1'b0, 1'b1, FwdNone);
        addAlu("link use go", 3'd7, 3'd0, 3'd0, 1'b0, 1'b0, 1'b0, FwdNone);
        addFill(4);
        runRows();

        writeCfg(1'b1, 1'b1);

        // Forwarding mode
        addAlu("fwd writer", 3'd1, 3'd2, 3'd3, 1'b1, 1'b0, 1'b0, FwdNone);
        addAlu("fwd ex", 3'd3, 3'd4, 3'd0, 1'b0, 1'b0, 1'b0, FwdEx);
        addAlu("fwd mem", 3'd3, 3'd4, 3'd0, 1'b0, 1'b0, 1'b0, FwdMem);
        addFill(4);

        // Writer seen through rt in every stage, MEM and WB have no path
        addAlu("fwd writer rt", 3'd1, 3'd2, 3'd3, 1'b1, 1'b0, 1'b0, FwdNone);
        addAlu("fwd ex rt", 3'd4, 3'd3, 3'd0, 1'b0, 1'b0, 1'b0, FwdExRt);
        addAlu("fwd mem rt", 3'd4, 3'd3, 3'd0, 1'b0, 1'b0, 1'b0, FwdMemRt);
        addAlu("fwd late MEM", 3'd4, 3'd3, 3'd0, 1'b0, 1'b0, 1'b1, FwdNone);
        addAlu("fwd late WB", 3'd4, 3'd3, 3'd0, 1'b0, 1'b0, 1'b1, FwdNone);
        addAlu("fwd late go", 3'd4, 3'd3, 3'd0, 1'b0, 1'b0, 1'b0, FwdNone);
        addFill(4);

        addMem("load", hazPkg::OpLd, 3'd3, 1'b1, 16'h0040, 16'h0004, 1'b0);
        addAlu("load use stall", 3'd3, 3'd0, 3'd0, 1'b0, 1'b0, 1'b1, FwdNone);
        addAlu("load use go", 3'd3, 3'd0, 3'd0, 1'b0, 1'b0, 1'b0, FwdMem);
        addFill(4);

        // Same effective address 0x0120 from different base and offset
        addMem("st first", hazPkg::OpSt, 3'd0, 1'b0, 16'h0100, 16'h0020, 1'b0);
        addMem("st same 1", hazPkg::OpSt, 3'd0, 1'b0, 16'h0110, 16'h0010, 1'b1);
        addMem("st same 2", hazPkg::OpSt, 3'd0, 1'b0, 16'h0110, 16'h0010, 1'b1);
        addMem("st same 3", hazPkg::OpSt, 3'd0, 1'b0, 16'h0110, 16'h0010, 1'b1);
        addMem("st same 4", hazPkg::OpSt, 3'd0, 1'b0, 16'h0110, 16'h0010, 1'b1);
        addMem("st same go", hazPkg::OpSt, 3'd0, 1'b0, 16'h0110, 16'h0010, 1'b0);
        addMem("st other", hazPkg::OpSt, 3'd0, 1'b0, 16'h0200, 16'h0000, 1'b0);
        addFill(4);
        runRows();

        writeCfg(1'b1, 1'b0);

        // Memory check off
        addMem("nochk first", hazPkg::OpSt, 3'd0, 1'b0, 16'h0100, 16'h0020, 1'b0);
        addMem("nochk same", hazPkg::OpSt, 3'd0, 1'b0, 16'h0110, 16'h0010, 1'b0);
        addFill(4);
        runRows();

        $display("** PASS **");
        $finish;
    end

endmodule
